// File: include/vec_settings.svh
// Vector unit settings
// Lane count, element width and register count shared by the
// package, the RTL and the testbench
`ifndef VEC_SETTINGS_SVH
`define VEC_SETTINGS_SVH

// element lanes, one element per lane
`define VEC_NUM_LANES 4

// element width in bits
`define VEC_ELEN 32

// architectural vector registers, 5 bit addresses
`define VEC_NUM_REGS 32

// full vector width in bits
`define VEC_VLEN (`VEC_NUM_LANES * `VEC_ELEN)

`endif

// File: logic/vec_pkg.sv
// Vector unit package
// Opcode enum and the packed structs that travel between the issue
// stage, the element lanes, writeback and the register file
`include "vec_settings.svh"

package vec_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // basic types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [$clog2(`VEC_NUM_REGS)-1:0] vec_addr_t;  // register address
  typedef logic [`VEC_ELEN-1:0]             vec_elem_t;  // one element
  typedef logic [`VEC_VLEN-1:0]             vec_data_t;  // whole register

  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,  // vs1 + vs2
    OP_SUB  = 3'd1,  // vs1 - vs2
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_MUL  = 3'd5,  // low half of vs1 * vs2
    OP_MACC = 3'd6,  // vs1 * vs2 + old vd, low half
    OP_MV   = 3'd7   // copy of vs1
  } vec_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    vec_op_e   op;
    logic      vm;   // 1 = unmasked
    vec_addr_t vd;
    vec_addr_t vs1;
    vec_addr_t vs2;
  } vec_instr_t;

  typedef struct packed {
    vec_op_e   op;
    logic      en;   // element active
    vec_elem_t a;    // vs1 element
    vec_elem_t b;    // vs2 element
    vec_elem_t c;    // old vd element
  } lane_op_t;

  typedef struct packed {
    vec_addr_t addr;
    vec_data_t data;
  } vec_wr_t;

endpackage

// File: logic/vec_reg_file.sv
// Vector register file
// 32 vector registers, cleared on reset, with three combinational
// read ports and one write port. Reads see a same-cycle write
// (write-through). The low bits of v0 are tapped as the element mask.
`timescale 1ns/1ns
`include "vec_settings.svh"

module vec_reg_file (
  input  logic                           clk_i,       // core clock
  input  logic                           reset_i,     // sync, active high
  input  logic                           wr_valid_i,  // write strobe
  input  vec_pkg::vec_wr_t               wr_i,        // write addr + data
  input  vec_pkg::vec_addr_t [2:0]       rs_addr_i,   // vs1, vs2, vd
  output vec_pkg::vec_data_t [2:0]       rs_data_o,   // read data
  output logic [`VEC_NUM_LANES-1:0]      mask_o       // v0 mask bits
);

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  vec_pkg::vec_data_t regs_q [`VEC_NUM_REGS];  // register array
  vec_pkg::vec_data_t v0_rd;                    // v0 as seen this cycle

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int r = 0; r < `VEC_NUM_REGS; r++) begin
        regs_q[r] <= '0;                        // all registers zero
      end
    end else if (wr_valid_i) begin
      regs_q[wr_i.addr] <= wr_i.data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read ports
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int p = 0; p < 3; p++) begin
      if (wr_valid_i && (wr_i.addr == rs_addr_i[p])) begin
        rs_data_o[p] = wr_i.data;               // bypass pending write
      end else begin
        rs_data_o[p] = regs_q[rs_addr_i[p]];
      end
    end
  end

  // v0 follows the same write-through rule as the read ports
  assign v0_rd = (wr_valid_i && (wr_i.addr == '0)) ? wr_i.data : regs_q[0];

  for (genvar i = 0; i < `VEC_NUM_LANES; i++) begin : g_mask
    assign mask_o[i] = v0_rd[i];                // mask bit i = v0 bit i
  end

endmodule

// File: logic/vec_issue.sv
// Vector issue stage
// Samples the instruction strobe, reads vs1, vs2 and the old vd from
// the register file, slices them into elements and registers one
// packet per lane. Keeps a two-entry vd history of the younger
// in-flight instructions to check the host's spacing rule.
`timescale 1ns/1ns
`include "vec_settings.svh"

module vec_issue (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   instr_valid_i,  // issue strobe
  input  vec_pkg::vec_instr_t                    instr_i,
  output vec_pkg::vec_addr_t [2:0]               rs_addr_o,      // vs1, vs2, vd
  input  vec_pkg::vec_data_t [2:0]               rs_data_i,
  input  logic [`VEC_NUM_LANES-1:0]              mask_i,         // v0 low bits
  output logic                                   lane_valid_o,   // packets valid
  output vec_pkg::lane_op_t [`VEC_NUM_LANES-1:0] lane_op_o,      // per lane
  output vec_pkg::vec_addr_t                     vd_o            // vd at lane stage
);

  ////////////////////////////////////////////////////////////////////////////
  // signals
  ////////////////////////////////////////////////////////////////////////////

  vec_pkg::lane_op_t [`VEC_NUM_LANES-1:0] lane_op_d;  // packets before reg
  logic [1:0]                             hist_valid_q; // [0] issue, [1] lanes
  vec_pkg::vec_addr_t [1:0]               hist_vd_q;    // matching vd
  logic                                   hazard;       // spacing violated

  ////////////////////////////////////////////////////////////////////////////
  // operand read and slicing
  ////////////////////////////////////////////////////////////////////////////

  assign rs_addr_o[0] = instr_i.vs1;
  assign rs_addr_o[1] = instr_i.vs2;
  assign rs_addr_o[2] = instr_i.vd;  // old vd, also the accumulator

  always_comb begin
    for (int i = 0; i < `VEC_NUM_LANES; i++) begin
      lane_op_d[i].op = instr_i.op;
      lane_op_d[i].en = instr_i.vm | mask_i[i];               // unmasked or v0 set
      lane_op_d[i].a  = rs_data_i[0][i*`VEC_ELEN +: `VEC_ELEN];
      lane_op_d[i].b  = rs_data_i[1][i*`VEC_ELEN +: `VEC_ELEN];
      lane_op_d[i].c  = rs_data_i[2][i*`VEC_ELEN +: `VEC_ELEN];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hist_valid_q <= '0;
    end else begin
      hist_valid_q <= {hist_valid_q[0], instr_valid_i};  // shift with the pipe
    end
  end

  always_ff @(posedge clk_i) begin
    hist_vd_q <= {hist_vd_q[0], instr_i.vd};
    if (instr_valid_i) begin
      lane_op_o <= lane_op_d;                             // hold when idle
    end
  end

  assign lane_valid_o = hist_valid_q[0];
  assign vd_o         = hist_vd_q[1];  // one stage older, lines up with lane results

  ////////////////////////////////////////////////////////////////////////////
  // spacing check
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    hazard = 1'b0;
    for (int k = 0; k < 2; k++) begin
      if (hist_valid_q[k] && ((instr_i.vs1 == hist_vd_q[k]) ||
                              (instr_i.vs2 == hist_vd_q[k]) ||
                              (instr_i.vd  == hist_vd_q[k]))) begin
        hazard = 1'b1;                                    // producer still in flight
      end
    end
  end

  // no forwarding, so a dependent instruction needs 3 cycles of spacing
  a_spacing : assert property (
    @(posedge clk_i) disable iff (reset_i)
    instr_valid_i |-> !hazard
  ) else $error("issue: instruction depends on in-flight vd");

endmodule

// File: logic/vec_lane.sv
// Vector element lane
// Computes one element of the result: add, subtract, logic ops, the
// low half of the product, multiply-accumulate or move. Registers the
// result, or keeps the old vd element when the element is masked off.
`timescale 1ns/1ns
`include "vec_settings.svh"

module vec_lane (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  valid_i,   // packet strobe from issue
  input  vec_pkg::lane_op_t     op_i,      // op, enable, a, b, c
  output logic                  valid_o,   // result strobe
  output vec_pkg::vec_elem_t    result_o   // merged element
);

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  vec_pkg::vec_elem_t prod;   // low half of a * b
  vec_pkg::vec_elem_t calc;   // unmasked result
  vec_pkg::vec_elem_t merged; // after mask merge

  assign prod = op_i.a * op_i.b;  // 32 bit context keeps low half

  always_comb begin
    case (op_i.op)
      vec_pkg::OP_ADD:  calc = op_i.a + op_i.b;
      vec_pkg::OP_SUB:  calc = op_i.a - op_i.b;
      vec_pkg::OP_AND:  calc = op_i.a & op_i.b;
      vec_pkg::OP_OR:   calc = op_i.a | op_i.b;
      vec_pkg::OP_XOR:  calc = op_i.a ^ op_i.b;
      vec_pkg::OP_MUL:  calc = prod;
      vec_pkg::OP_MACC: calc = prod + op_i.c;   // accumulate into old vd
      vec_pkg::OP_MV:   calc = op_i.a;
      default:          calc = op_i.c;          // unreachable, keep vd
    endcase
  end

  assign merged = op_i.en ? calc : op_i.c;      // masked off keeps old vd

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_o <= merged;                       // merged element
    end
  end

endmodule

// File: logic/vec_writeback.sv
// Vector writeback stage
// Gathers the lane elements into a vector, picks between a retiring
// instruction and a host load, and registers the single register-file
// write. Only instructions raise the result strobe.
`timescale 1ns/1ns
`include "vec_settings.svh"

module vec_writeback (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic [`VEC_NUM_LANES-1:0]               lane_valid_i,   // one per lane
  input  vec_pkg::vec_elem_t [`VEC_NUM_LANES-1:0] lane_result_i,
  input  vec_pkg::vec_addr_t                      vd_i,           // retiring vd
  input  logic                                    load_valid_i,   // host load strobe
  input  vec_pkg::vec_wr_t                        load_i,
  output logic                                    wr_valid_o,     // reg file write
  output vec_pkg::vec_wr_t                        wr_o,
  output logic                                    result_valid_o  // instr result only
);

  logic             retire;  // instruction leaving the lanes
  vec_pkg::vec_wr_t wr_d;    // selected write

  assign retire = lane_valid_i[0];  // lanes run in lockstep

  always_comb begin
    if (retire) begin
      wr_d.addr = vd_i;
      wr_d.data = lane_result_i;    // lane 0 in the low element
    end else begin
      wr_d = load_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_valid_o     <= 1'b0;
      result_valid_o <= 1'b0;
    end else begin
      wr_valid_o     <= retire | load_valid_i;
      result_valid_o <= retire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire || load_valid_i) begin
      wr_o <= wr_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_lanes_agree : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (&lane_valid_i) || !(|lane_valid_i)
  ) else $error("writeback: lane valids disagree %b", lane_valid_i);

  // host only loads while the pipeline is empty
  a_no_collision : assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(load_valid_i && retire)
  ) else $error("writeback: load collides with retiring instruction");

endmodule

// File: logic/vec_unit_top.sv
// Vector unit top
// Issue stage, register file, element lanes and writeback. An
// instruction sampled in cycle T reports its result in T+3 and the
// register file is written with the same value in that cycle.
`timescale 1ns/1ns
`include "vec_settings.svh"

module vec_unit_top (
  input  logic                clk_i,
  input  logic                reset_i,         // sync, active high
  input  logic                instr_valid_i,
  input  vec_pkg::vec_instr_t instr_i,
  input  logic                load_valid_i,    // host register load
  input  vec_pkg::vec_wr_t    load_i,
  output logic                result_valid_o,
  output vec_pkg::vec_wr_t    result_o         // vd and result vector
);

  ////////////////////////////////////////////////////////////////////////////
  // interconnect
  ////////////////////////////////////////////////////////////////////////////

  vec_pkg::vec_addr_t [2:0]               rs_addr;      // issue to reg file
  vec_pkg::vec_data_t [2:0]               rs_data;
  logic [`VEC_NUM_LANES-1:0]              mask;         // v0 bits
  logic                                   issue_valid;
  vec_pkg::lane_op_t [`VEC_NUM_LANES-1:0] lane_op;
  vec_pkg::vec_addr_t                     vd;           // aligned to lane outputs
  logic [`VEC_NUM_LANES-1:0]              lane_valid;
  vec_pkg::vec_elem_t [`VEC_NUM_LANES-1:0] lane_result;
  logic                                   wr_valid;     // reg file write
  vec_pkg::vec_wr_t                       wr;

  ////////////////////////////////////////////////////////////////////////////
  // instances
  ////////////////////////////////////////////////////////////////////////////

  vec_issue i_issue (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i),
    .rs_addr_o    (rs_addr),
    .rs_data_i    (rs_data),
    .mask_i       (mask),
    .lane_valid_o (issue_valid),
    .lane_op_o    (lane_op),
    .vd_o         (vd)
  );

  vec_reg_file i_reg_file (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wr_valid_i(wr_valid),
    .wr_i      (wr),
    .rs_addr_i (rs_addr),
    .rs_data_o (rs_data),
    .mask_o    (mask)
  );

  for (genvar i = 0; i < `VEC_NUM_LANES; i++) begin : g_lane
    vec_lane i_lane (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .valid_i (issue_valid),
      .op_i    (lane_op[i]),
      .valid_o (lane_valid[i]),
      .result_o(lane_result[i])
    );
  end

  vec_writeback i_writeback (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .lane_valid_i  (lane_valid),
    .lane_result_i (lane_result),
    .vd_i          (vd),
    .load_valid_i  (load_valid_i),
    .load_i        (load_i),
    .wr_valid_o    (wr_valid),
    .wr_o          (wr),
    .result_valid_o(result_valid_o)
  );

  assign result_o = wr;  // result report is the reg file write

endmodule

// File: tb/vec_unit_tb.sv
// Vector unit testbench
// Drives loads and instructions into the vector unit, keeps a register
// model, queues the expected writes with their issue cycle and checks
// every result strobe with concurrent assertions.
`timescale 1ns/1ns
`include "vec_settings.svh"

module vec_unit_tb;

  localparam int CLK_PERIOD = 8;
  localparam int ELEN       = `VEC_ELEN;
  localparam int N_ALU      = 40;                    // ops in the alu and mask tests
  localparam int N_PIPE     = 48;                    // back-to-back ops
  localparam int WATCHDOG_CYCLES = 5 + 46 + 32 * 10 + N_ALU * 3 + 10 + N_ALU * 3 + 40
                                   + 4 * (8 * 3 + 6) + N_PIPE + 10 + 200;  // plus margin

  typedef struct packed {
    vec_pkg::vec_wr_t wr;     // expected write
    logic [31:0]      cycle;  // cycle the instruction was driven
  } exp_entry_t;

  logic                clk;
  logic                reset;
  logic                instr_valid;
  vec_pkg::vec_instr_t instr;
  logic                load_valid;
  vec_pkg::vec_wr_t    load;
  logic                result_valid;
  vec_pkg::vec_wr_t    result;

  vec_pkg::vec_data_t model_regs [`VEC_NUM_REGS];  // reference register file
  exp_entry_t         exp_q [$];                   // expected results in order
  logic [31:0]        cycle_cnt;
  int                 err_cnt;
  int                 pass_cnt;
  int                 fail_cnt;

  // snapshot taken at the falling edge, stable for the assertions
  logic               chk_valid;
  logic               chk_empty;   // strobe with nothing queued
  vec_pkg::vec_wr_t   chk_got;
  exp_entry_t         chk_head;
  logic [31:0]        chk_cycle;
  logic               overdue;     // head missed its cycle

  vec_unit_top i_dut (
    .clk_i         (clk),
    .reset_i       (reset),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .load_valid_i  (load_valid),
    .load_i        (load),
    .result_valid_o(result_valid),
    .result_o      (result)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    if (reset) cycle_cnt <= '0;
    else       cycle_cnt <= cycle_cnt + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // result capture and checks
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    chk_valid = result_valid;
    chk_got   = result;
    chk_cycle = cycle_cnt;
    if (result_valid) begin
      chk_empty = (exp_q.size() == 0);
      if (!chk_empty) chk_head = exp_q.pop_front();
    end
    overdue = (exp_q.size() != 0) && (cycle_cnt > exp_q[0].cycle + 3);
  end

  a_expected : assert property (@(posedge clk) disable iff (reset)
    chk_valid |-> !chk_empty)
    else begin
      err_cnt++;
      $display("result_valid_o raised with no instruction in flight");
    end

  a_addr : assert property (@(posedge clk) disable iff (reset)
    (chk_valid && !chk_empty) |-> (chk_got.addr == chk_head.wr.addr))
    else begin
      err_cnt++;
      $display("mismatch result_o.addr: got %h expected %h", chk_got.addr, chk_head.wr.addr);
    end

  a_data : assert property (@(posedge clk) disable iff (reset)
    (chk_valid && !chk_empty) |-> (chk_got.data == chk_head.wr.data))
    else begin
      err_cnt++;
      $display("mismatch result_o.data: got %h expected %h", chk_got.data, chk_head.wr.data);
    end

  // exactly three cycles from issue to result
  a_latency : assert property (@(posedge clk) disable iff (reset)
    (chk_valid && !chk_empty) |-> (chk_cycle == chk_head.cycle + 3))
    else begin
      err_cnt++;
      $display("result arrived in cycle %0d but was due in cycle %0d",
               chk_cycle, chk_head.cycle + 3);
    end

  a_on_time : assert property (@(posedge clk) disable iff (reset) !overdue)
    else begin
      err_cnt++;
      $display("an expected result did not arrive by its cycle");
    end

  ////////////////////////////////////////////////////////////////////////////
  // model and stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic vec_pkg::vec_data_t expected_vec(input vec_pkg::vec_instr_t ins);
    vec_pkg::vec_data_t res;
    logic [ELEN-1:0]    ea, eb, ec, ev;
    logic [2*ELEN-1:0]  full;
    for (int i = 0; i < `VEC_NUM_LANES; i++) begin
      ea   = model_regs[ins.vs1][i*ELEN +: ELEN];
      eb   = model_regs[ins.vs2][i*ELEN +: ELEN];
      ec   = model_regs[ins.vd][i*ELEN +: ELEN];
      full = {{ELEN{1'b0}}, ea} * {{ELEN{1'b0}}, eb};  // full product, keep low half
      case (ins.op)
        vec_pkg::OP_ADD:  ev = ea + eb;
        vec_pkg::OP_SUB:  ev = ea - eb;
        vec_pkg::OP_AND:  ev = ea & eb;
        vec_pkg::OP_OR:   ev = ea | eb;
        vec_pkg::OP_XOR:  ev = ea ^ eb;
        vec_pkg::OP_MUL:  ev = full[ELEN-1:0];
        vec_pkg::OP_MACC: ev = full[ELEN-1:0] + ec;
        default:          ev = ea;             // move
      endcase
      if (!ins.vm && !model_regs[0][i]) ev = ec;  // masked off, old vd stays
      res[i*ELEN +: ELEN] = ev;
    end
    return res;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;                                         // drive just after the edge
  endtask

  function automatic vec_pkg::vec_addr_t rand_reg(input int lo, input int hi);
    int unsigned r;
    r = $urandom_range(hi, lo);
    return vec_pkg::vec_addr_t'(r);
  endfunction

  function automatic vec_pkg::vec_data_t rand_vec();
    vec_pkg::vec_data_t v;
    for (int i = 0; i < `VEC_NUM_LANES; i++) v[i*ELEN +: ELEN] = $urandom();
    return v;
  endfunction

  task automatic issue_instr(input vec_pkg::vec_op_e op, input logic vm,
                             input vec_pkg::vec_addr_t vd, input vec_pkg::vec_addr_t vs1,
                             input vec_pkg::vec_addr_t vs2);
    vec_pkg::vec_instr_t ins;
    exp_entry_t          e;
    ins = '{op: op, vm: vm, vd: vd, vs1: vs1, vs2: vs2};
    e.wr.addr = vd;
    e.wr.data = expected_vec(ins);
    e.cycle   = cycle_cnt;
    model_regs[vd] = e.wr.data;
    exp_q.push_back(e);
    instr       = ins;
    instr_valid = 1'b1;
    step();
    instr_valid = 1'b0;
  endtask

  task automatic load_reg(input vec_pkg::vec_addr_t addr, input vec_pkg::vec_data_t data);
    model_regs[addr] = data;
    load       = '{addr: addr, data: data};
    load_valid = 1'b1;
    step();
    load_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) step();           // watchdog bounds this
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int                 base;
    vec_pkg::vec_addr_t vd;
    vec_pkg::vec_addr_t vs1;
    vec_pkg::vec_addr_t vs2;
    void'($urandom(32'h97468899));
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    load_valid  = 1'b0;
    load        = '0;
    err_cnt     = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    chk_valid   = 1'b0;
    chk_empty   = 1'b0;
    chk_head    = '0;
    chk_got     = '0;
    overdue     = 1'b0;
    for (int r = 0; r < `VEC_NUM_REGS; r++) model_regs[r] = '0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    base = err_cnt;                             // quiet after reset, then zeros
    repeat (8) step();
    for (int r = 0; r < `VEC_NUM_REGS; r++) begin
      vd = vec_pkg::vec_addr_t'(r);
      issue_instr(vec_pkg::OP_MV, 1'b1, vd, vd, vd);
    end
    wait_drain();
    finish_test("reset_zero", base);

    base = err_cnt;
    for (int r = 0; r < `VEC_NUM_REGS; r++) begin
      vs1 = vec_pkg::vec_addr_t'(r);
      vd  = vec_pkg::vec_addr_t'(r + 1);        // wraps to v0
      load_reg(vs1, rand_vec());
      issue_instr(vec_pkg::OP_MV, 1'b1, vd, vs1, vs1);
      repeat (2) step();
      issue_instr(vec_pkg::OP_MV, 1'b1, vd, vd, vd);  // reads back the copy
      wait_drain();
    end
    finish_test("load_move", base);

    base = err_cnt;
    for (int k = 0; k < N_ALU; k++) begin
      issue_instr(vec_pkg::vec_op_e'($urandom_range(5, 0)), 1'b1,
                  rand_reg(0, 31), rand_reg(0, 31), rand_reg(0, 31));
      repeat (2) step();
    end
    wait_drain();
    finish_test("alu_unmasked", base);

    base = err_cnt;
    for (int k = 0; k < N_ALU; k++) begin
      if (k % 10 == 0) begin
        wait_drain();
        load_reg('0, rand_vec());               // fresh mask in v0
      end
      issue_instr(vec_pkg::vec_op_e'($urandom_range(7, 0)), 1'b0,
                  rand_reg(1, 31), rand_reg(0, 31), rand_reg(0, 31));
      repeat (2) step();
    end
    wait_drain();
    finish_test("masked", base);

    base = err_cnt;
    for (int c = 0; c < 4; c++) begin
      vd  = rand_reg(8, 31);
      vs1 = rand_reg(0, 7);
      vs2 = rand_reg(0, 7);
      for (int k = 0; k < 8; k++) begin
        issue_instr(vec_pkg::OP_MACC, 1'b1, vd, vs1, vs2);
        repeat (2) step();
      end
      wait_drain();
    end
    finish_test("macc_chain", base);

    base = err_cnt;                             // one per cycle, vd rotates over six
    for (int k = 0; k < N_PIPE; k++) begin
      issue_instr(vec_pkg::vec_op_e'($urandom_range(7, 0)), 1'($urandom_range(1, 0)),
                  vec_pkg::vec_addr_t'(10 + k % 6), rand_reg(1, 4), rand_reg(1, 4));
    end
    wait_drain();
    repeat (4) step();
    finish_test("pipelined", base);

    $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: flist.f
+incdir+include
logic/vec_pkg.sv
logic/vec_reg_file.sv
logic/vec_issue.sv
logic/vec_lane.sv
logic/vec_writeback.sv
logic/vec_unit_top.sv
tb/vec_unit_tb.sv

// File: Makefile
# Verilator build and run for the vector unit testbench
TOP := vec_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
		--top-module $(TOP) -f flist.f

# the simulator's own exit code is ignored, the log decides
run: compile
	-./obj_dir/V$(TOP) > run.log 2>&1
	cat run.log
	grep -q "^Testbench passed$$" run.log

clean:
	rm -rf obj_dir run.log
